/* src/csr_cfg.svh */
`ifndef CSR_CFG_SVH
`define CSR_CFG_SVH

// Request queue depth
// Also the number of credits the sender holds after reset
`define CSR_QDEPTH 2

// Trap vector after reset
// Direct mode only, the low bits are kept as written
`define CSR_MTVEC_RST 32'h0000_0100

// Privilege mode after reset, machine mode
`define CSR_MODE_RST 2'b11

// mcause for the machine timer interrupt
// Bit 31 marks an interrupt, exception code 7
`define CSR_CAUSE_MTI 32'h8000_0007

// Exception code base for ECALL
// U gives 8, M gives 11
`define CSR_CAUSE_ECALL 4'd8

`endif

/* src/csr_pkg.sv */
package csr_pkg;

    // CSR request opcodes from the pipeline
    typedef enum logic [2:0] {
        CSR_NOP   = 3'd0,
        CSR_W     = 3'd1,
        CSR_S     = 3'd2,
        CSR_C     = 3'd3,
        CSR_ECALL = 3'd4,
        CSR_MRET  = 3'd5
    } csr_op_e;

    // Only U and M, no supervisor
    typedef enum logic [1:0] {
        PRIV_U = 2'b00,
        PRIV_M = 2'b11
    } priv_mode_e;

    typedef enum logic [1:0] {
        RSP_DATA     = 2'd0,
        RSP_REDIRECT = 2'd1,
        RSP_IRQ      = 2'd2
    } csr_rsp_kind_e;

    // One request, 79 bits
    typedef struct packed {
        csr_op_e     op;
        logic [11:0] addr;
        // rs1 operand
        logic [31:0] wdata;
        // Instruction address, becomes mepc on a trap
        logic [31:0] pc;
    } csr_req_t;

    // One response, 66 bits
    typedef struct packed {
        csr_rsp_kind_e kind;
        logic [31:0]   rdata;
        logic [31:0]   target;
    } csr_rsp_t;

    // Result of one side block for the head request
    typedef struct packed {
        logic        hit;
        logic [31:0] rdata;
        logic        redirect;
        logic [31:0] target;
    } csr_part_t;

    // CSR addresses
    localparam logic [11:0] CSR_ADDR_MSTATUS  = 12'h300;
    localparam logic [11:0] CSR_ADDR_MIE      = 12'h304;
    localparam logic [11:0] CSR_ADDR_MTVEC    = 12'h305;
    localparam logic [11:0] CSR_ADDR_MSCRATCH = 12'h340;
    localparam logic [11:0] CSR_ADDR_MEPC     = 12'h341;
    localparam logic [11:0] CSR_ADDR_MCAUSE   = 12'h342;
    localparam logic [11:0] CSR_ADDR_TIME     = 12'hc01;
    localparam logic [11:0] CSR_ADDR_TIMEH    = 12'hc81;

    // True for the opcodes that read and modify a CSR
    function automatic logic csr_is_access(csr_op_e op);
        return (op == CSR_W) || (op == CSR_S) || (op == CSR_C);
    endfunction

    // New CSR value for W, S and C
    function automatic logic [31:0] csr_rmw(csr_op_e op, logic [31:0] old_val,
                                            logic [31:0] wdata);
        case (op)
            CSR_W:   return wdata;
            CSR_S:   return old_val | wdata;
            CSR_C:   return old_val & ~wdata;
            default: return old_val;
        endcase
    endfunction

endpackage

/* src/csr_req_queue.sv */
`timescale 1ns/1ps
`include "csr_cfg.svh"

module csr_req_queue (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              req_valid,
    input  csr_pkg::csr_req_t req,
    input  logic              irq_stall,
    output logic              head_valid,
    output csr_pkg::csr_req_t head,
    output logic              fire,
    output logic              credit_return
);

    localparam int DEPTH = `CSR_QDEPTH;
    localparam int PW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW    = $clog2(DEPTH + 1);

    // Entry storage
    csr_pkg::csr_req_t mem [DEPTH];

    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [CW-1:0] count;

    // Wraps at DEPTH for any depth
    function automatic logic [PW-1:0] ptr_inc(logic [PW-1:0] ptr);
        if (ptr == PW'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign head_valid = (count != '0);
    assign head       = mem[rd_ptr];
    // Head leaves unless a timer interrupt is waiting for irq_ready
    assign fire       = head_valid & ~irq_stall;

    // The sender's credits guarantee a free slot
    always_ff @(posedge clk) begin
        if (req_valid) begin
            mem[wr_ptr] <= req;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            credit_return <= 1'b0;
        end else begin
            if (req_valid) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (fire) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({req_valid, fire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // One credit back per retired entry, a cycle after the pop
            credit_return <= fire;
        end
    end

endmodule

/* src/csr_regfile.sv */
`timescale 1ns/1ps
`include "csr_cfg.svh"

module csr_regfile (
    input  logic               clk,
    input  logic               rst_n,
    input  csr_pkg::csr_req_t  head,
    input  logic               fire,
    input  logic               irq_take,
    input  logic [63:0]        time_now,
    output csr_pkg::csr_part_t part,
    output logic [31:0]        mtvec,
    output logic               mie_mtie
);

    logic [31:0] mscratch_q;
    logic [31:0] mtvec_q;
    // Only MTIE is implemented in mie
    logic        mie_mtie_q;

    logic        owned;
    logic        writable;
    logic        access;
    logic [31:0] old_val;
    logic [31:0] new_val;
    logic        do_write;

    // Address decode and old value
    always_comb begin
        owned    = 1'b1;
        writable = 1'b1;
        old_val  = '0;
        case (head.addr)
            csr_pkg::CSR_ADDR_MSCRATCH: old_val = mscratch_q;
            csr_pkg::CSR_ADDR_MTVEC:    old_val = mtvec_q;
            // MTIE at bit 7, the rest reads zero
            csr_pkg::CSR_ADDR_MIE:      old_val = {24'b0, mie_mtie_q, 7'b0};
            csr_pkg::CSR_ADDR_TIME: begin
                old_val  = time_now[31:0];
                writable = 1'b0;
            end
            csr_pkg::CSR_ADDR_TIMEH: begin
                old_val  = time_now[63:32];
                writable = 1'b0;
            end
            default: begin
                owned    = 1'b0;
                writable = 1'b0;
            end
        endcase
    end

    assign access  = csr_pkg::csr_is_access(head.op);
    assign new_val = csr_pkg::csr_rmw(head.op, old_val, head.wdata);

    // An interrupted head is retired without executing
    assign do_write = fire & ~irq_take & access & writable;

    // Plain registers never redirect
    always_comb begin
        part.hit      = owned & access;
        part.rdata    = (owned & access) ? old_val : '0;
        part.redirect = 1'b0;
        part.target   = '0;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mscratch_q <= '0;
            mtvec_q    <= `CSR_MTVEC_RST;
            mie_mtie_q <= 1'b0;
        end else if (do_write) begin
            case (head.addr)
                csr_pkg::CSR_ADDR_MSCRATCH: mscratch_q <= new_val;
                csr_pkg::CSR_ADDR_MTVEC:    mtvec_q    <= new_val;
                csr_pkg::CSR_ADDR_MIE:      mie_mtie_q <= new_val[7];
                default: begin
                end
            endcase
        end
    end

    // To the trap block
    assign mtvec    = mtvec_q;
    assign mie_mtie = mie_mtie_q;

endmodule

/* src/csr_trap_ctrl.sv */
`timescale 1ns/1ps
`include "csr_cfg.svh"

module csr_trap_ctrl (
    input  logic               clk,
    input  logic               rst_n,
    input  csr_pkg::csr_req_t  head,
    input  logic               head_valid,
    input  logic               fire,
    input  logic               irq_ready,
    input  logic [63:0]        time_now,
    input  logic [63:0]        mtimecmp,
    input  logic [31:0]        mtvec,
    input  logic               mie_mtie,
    output logic               irq_stall,
    output logic               irq_take,
    output csr_pkg::csr_part_t part
);

    csr_pkg::priv_mode_e mode_q;
    // mstatus fields
    logic                mst_mie_q;
    logic                mst_mpie_q;
    csr_pkg::priv_mode_e mst_mpp_q;
    logic [31:0]         mepc_q;
    logic [31:0]         mcause_q;

    logic [31:0] mstatus_rd;
    logic [31:0] old_val;
    logic [31:0] new_val;
    logic        owned;
    logic        access;
    logic        irq_pending;
    logic        trap_enter;
    logic        is_mret;

    // Timer interrupt, U mode is always interruptible
    assign irq_pending = (time_now >= mtimecmp) && mie_mtie &&
                         ((mode_q == csr_pkg::PRIV_M && mst_mie_q) ||
                          (mode_q == csr_pkg::PRIV_U));
    // Hold the queue until the pipeline can take the trap
    assign irq_stall   = irq_pending & ~irq_ready;
    assign irq_take    = irq_pending & irq_ready & head_valid;

    assign mstatus_rd = {19'b0, mst_mpp_q, 3'b0, mst_mpie_q, 3'b0, mst_mie_q, 3'b0};

    always_comb begin
        owned   = 1'b1;
        old_val = '0;
        case (head.addr)
            csr_pkg::CSR_ADDR_MSTATUS: old_val = mstatus_rd;
            csr_pkg::CSR_ADDR_MEPC:    old_val = mepc_q;
            csr_pkg::CSR_ADDR_MCAUSE:  old_val = mcause_q;
            default:                   owned   = 1'b0;
        endcase
    end

    assign access  = csr_pkg::csr_is_access(head.op);
    assign new_val = csr_pkg::csr_rmw(head.op, old_val, head.wdata);

    // ECALL and the timer interrupt share the trap entry
    assign trap_enter = irq_take | (fire & (head.op == csr_pkg::CSR_ECALL));
    assign is_mret    = ~irq_take & (head.op == csr_pkg::CSR_MRET);

    always_comb begin
        part.hit      = owned & access;
        part.rdata    = (owned & access) ? old_val : '0;
        part.redirect = (head.op == csr_pkg::CSR_ECALL) | (head.op == csr_pkg::CSR_MRET);
        // MRET returns to the old mepc, every trap goes to mtvec
        part.target   = is_mret ? mepc_q : mtvec;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mode_q     <= csr_pkg::priv_mode_e'(`CSR_MODE_RST);
            mst_mie_q  <= 1'b0;
            mst_mpie_q <= 1'b0;
            mst_mpp_q  <= csr_pkg::PRIV_U;
            mepc_q     <= '0;
            mcause_q   <= '0;
        end else if (trap_enter) begin
            // Cause 8 plus mode for ECALL
            mcause_q   <= irq_take ? `CSR_CAUSE_MTI :
                          {28'b0, `CSR_CAUSE_ECALL + {2'b0, mode_q}};
            mepc_q     <= head.pc;
            mst_mpp_q  <= mode_q;
            mst_mpie_q <= mst_mie_q;
            mst_mie_q  <= 1'b0;
            mode_q     <= csr_pkg::PRIV_M;
        end else if (fire && is_mret) begin
            mode_q     <= mst_mpp_q;
            mst_mie_q  <= mst_mpie_q;
            mst_mpie_q <= 1'b1;
            mst_mpp_q  <= csr_pkg::PRIV_U;
        end else if (fire && access) begin
            case (head.addr)
                csr_pkg::CSR_ADDR_MSTATUS: begin
                    mst_mie_q  <= new_val[3];
                    mst_mpie_q <= new_val[7];
                    // Unsupported modes fall back to U
                    mst_mpp_q  <= (new_val[12:11] == 2'b11) ? csr_pkg::PRIV_M :
                                                              csr_pkg::PRIV_U;
                end
                csr_pkg::CSR_ADDR_MEPC:   mepc_q   <= new_val;
                csr_pkg::CSR_ADDR_MCAUSE: mcause_q <= new_val;
                default: begin
                end
            endcase
        end
    end

endmodule

/* src/csr_rsp_stage.sv */
`timescale 1ns/1ps

module csr_rsp_stage (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               fire,
    input  logic               irq_take,
    input  csr_pkg::csr_part_t reg_part,
    input  csr_pkg::csr_part_t trap_part,
    output logic               rsp_valid,
    output csr_pkg::csr_rsp_t  rsp
);

    csr_pkg::csr_rsp_t rsp_next;

    // Interrupt first, then redirect, then read data
    always_comb begin
        rsp_next.kind   = csr_pkg::RSP_DATA;
        rsp_next.rdata  = '0;
        rsp_next.target = '0;
        if (irq_take) begin
            rsp_next.kind   = csr_pkg::RSP_IRQ;
            rsp_next.target = trap_part.target;
        end else if (trap_part.redirect) begin
            rsp_next.kind   = csr_pkg::RSP_REDIRECT;
            rsp_next.target = trap_part.target;
        end else if (reg_part.hit) begin
            rsp_next.rdata = reg_part.rdata;
        end else if (trap_part.hit) begin
            rsp_next.rdata = trap_part.rdata;
        end
        // NOP and unowned addresses give zero data
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_valid <= 1'b0;
        end else begin
            // One pulse per retired request
            rsp_valid <= fire;
        end
    end

    // Payload only loads on a retire
    always_ff @(posedge clk) begin
        if (fire) begin
            rsp <= rsp_next;
        end
    end

endmodule

/* src/csr_unit.sv */
`timescale 1ns/1ps

module csr_unit (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              req_valid,
    input  csr_pkg::csr_req_t req,
    output logic              credit_return,
    output logic              rsp_valid,
    output csr_pkg::csr_rsp_t rsp,
    input  logic [63:0]       time_now,
    input  logic [63:0]       mtimecmp,
    input  logic              irq_ready,
    output logic              irq_stall
);

    csr_pkg::csr_req_t  head;
    logic               head_valid;
    logic               fire;
    logic               irq_take;
    csr_pkg::csr_part_t reg_part;
    csr_pkg::csr_part_t trap_part;
    logic [31:0]        mtvec;
    logic               mie_mtie;

    // Credit queue, head pops on fire
    csr_req_queue u_queue (
        .clk           (clk),
        .rst_n         (rst_n),
        .req_valid     (req_valid),
        .req           (req),
        .irq_stall     (irq_stall),
        .head_valid    (head_valid),
        .head          (head),
        .fire          (fire),
        .credit_return (credit_return)
    );

    // Plain CSRs
    csr_regfile u_regfile (
        .clk      (clk),
        .rst_n    (rst_n),
        .head     (head),
        .fire     (fire),
        .irq_take (irq_take),
        .time_now (time_now),
        .part     (reg_part),
        .mtvec    (mtvec),
        .mie_mtie (mie_mtie)
    );

    // Mode, mstatus, trap entry and return
    csr_trap_ctrl u_trap (
        .clk        (clk),
        .rst_n      (rst_n),
        .head       (head),
        .head_valid (head_valid),
        .fire       (fire),
        .irq_ready  (irq_ready),
        .time_now   (time_now),
        .mtimecmp   (mtimecmp),
        .mtvec      (mtvec),
        .mie_mtie   (mie_mtie),
        .irq_stall  (irq_stall),
        .irq_take   (irq_take),
        .part       (trap_part)
    );

    csr_rsp_stage u_rsp (
        .clk       (clk),
        .rst_n     (rst_n),
        .fire      (fire),
        .irq_take  (irq_take),
        .reg_part  (reg_part),
        .trap_part (trap_part),
        .rsp_valid (rsp_valid),
        .rsp       (rsp)
    );

endmodule

/* tests/csr_clk_gen.sv */
`timescale 1ns/1ps

module csr_clk_gen (
    output logic clk,
    output logic rst_n
);

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    // Held low over three rising edges
    // Released on the next falling edge, away from the active edge
    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

/* tests/csr_props.sv */
`timescale 1ns/1ps
`include "csr_cfg.svh"

module csr_props (
    input logic clk,
    input logic rst_n,
    input logic req_valid,
    input logic credit_return,
    input logic rsp_valid,
    input logic irq_stall
);

    // Requests taken in and not yet credited back
    logic [7:0] outstanding;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            outstanding <= '0;
        end else begin
            outstanding <= outstanding + 8'(req_valid) - 8'(credit_return);
        end
    end

    // One credit per response, same cycle
    a_credit_matches_rsp: assert property (@(posedge clk) disable iff (!rst_n)
        credit_return == rsp_valid)
        else $error("credit_return and rsp_valid differ");

    // A credit seen in this cycle frees one slot
    a_no_send_when_full: assert property (@(posedge clk) disable iff (!rst_n)
        req_valid |-> ((outstanding < 8'(`CSR_QDEPTH)) || credit_return))
        else $error("request sent with the queue full");

    a_no_rsp_in_stall: assert property (@(posedge clk) disable iff (!rst_n)
        irq_stall |-> !rsp_valid)
        else $error("response during interrupt stall");

    a_quiet_in_reset: assert property (@(posedge clk)
        !rst_n |-> (!rsp_valid && !irq_stall))
        else $error("rsp_valid or irq_stall high during reset");

endmodule

bind csr_unit csr_props props_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_valid     (req_valid),
    .credit_return (credit_return),
    .rsp_valid     (rsp_valid),
    .irq_stall     (irq_stall)
);

/* tests/csr_tb.sv */
`timescale 1ns/1ps
`include "csr_cfg.svh"

module csr_tb;

    logic              clk;
    logic              rst_n;
    logic              req_valid;
    csr_pkg::csr_req_t req;
    logic              credit_return;
    logic              rsp_valid;
    csr_pkg::csr_rsp_t rsp;
    logic [63:0]       time_now;
    logic [63:0]       mtimecmp;
    logic              irq_ready;
    logic              irq_stall;

    integer seed;
    int     credits;
    // Expected responses in request order
    csr_pkg::csr_rsp_t exp_q[$];

    // Model of the CSR state
    logic [1:0]  m_mode;
    logic        m_mie;
    logic        m_mpie;
    logic [1:0]  m_mpp;
    logic [31:0] m_mepc;
    logic [31:0] m_mcause;
    logic [31:0] m_mscratch;
    logic [31:0] m_mtvec;
    logic        m_mtie;

    csr_clk_gen clk_gen_i (
        .clk   (clk),
        .rst_n (rst_n)
    );

    csr_unit dut_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .req_valid     (req_valid),
        .req           (req),
        .credit_return (credit_return),
        .rsp_valid     (rsp_valid),
        .rsp           (rsp),
        .time_now      (time_now),
        .mtimecmp      (mtimecmp),
        .irq_ready     (irq_ready),
        .irq_stall     (irq_stall)
    );

    task automatic fail_run(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_val(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("ERR time=%0t %s got=0x%0h exp=0x%0h",
                               $time, name, got, exp));
        end
    endtask

    function automatic csr_pkg::csr_req_t make_req(csr_pkg::csr_op_e op, logic [11:0] addr,
                                                   logic [31:0] wdata, logic [31:0] pc);
        csr_pkg::csr_req_t r;
        r.op    = op;
        r.addr  = addr;
        r.wdata = wdata;
        r.pc    = pc;
        return r;
    endfunction

    // Old value as the pipeline would read it, zero if unowned
    function automatic logic [31:0] model_read(logic [11:0] addr);
        case (addr)
            // MPP at 12:11, MPIE at 7, MIE at 3
            12'h300: return (32'(m_mpp) << 11) | (32'(m_mpie) << 7) | (32'(m_mie) << 3);
            12'h304: return 32'(m_mtie) << 7;
            12'h305: return m_mtvec;
            12'h340: return m_mscratch;
            12'h341: return m_mepc;
            12'h342: return m_mcause;
            12'hc01: return time_now[31:0];
            12'hc81: return time_now[63:32];
            default: return 32'h0;
        endcase
    endfunction

    // Executes one request on the model and queues its response
    task automatic model_exec(input csr_pkg::csr_req_t r, input logic take_irq);
        csr_pkg::csr_rsp_t e;
        logic [31:0]       old_val;
        logic [31:0]       new_val;
        e.kind   = csr_pkg::RSP_DATA;
        e.rdata  = '0;
        e.target = '0;
        if (take_irq || r.op == csr_pkg::CSR_ECALL) begin
            e.kind   = take_irq ? csr_pkg::RSP_IRQ : csr_pkg::RSP_REDIRECT;
            e.target = m_mtvec;
            // ECALL from U is 8, from M is 11
            if (take_irq) begin
                m_mcause = `CSR_CAUSE_MTI;
            end else begin
                m_mcause = (m_mode == 2'b11) ? 32'd11 : 32'd8;
            end
            m_mepc = r.pc;
            m_mpp  = m_mode;
            m_mpie = m_mie;
            m_mie  = 1'b0;
            m_mode = 2'b11;
        end else if (r.op == csr_pkg::CSR_MRET) begin
            e.kind   = csr_pkg::RSP_REDIRECT;
            e.target = m_mepc;
            m_mode   = m_mpp;
            m_mie    = m_mpie;
            m_mpie   = 1'b1;
            m_mpp    = 2'b00;
        end else if (r.op == csr_pkg::CSR_W || r.op == csr_pkg::CSR_S ||
                     r.op == csr_pkg::CSR_C) begin
            old_val = model_read(r.addr);
            if (r.op == csr_pkg::CSR_W) begin
                new_val = r.wdata;
            end else if (r.op == csr_pkg::CSR_S) begin
                new_val = old_val | r.wdata;
            end else begin
                new_val = old_val & ~r.wdata;
            end
            e.rdata = old_val;
            case (r.addr)
                12'h300: begin
                    m_mie  = new_val[3];
                    m_mpie = new_val[7];
                    // Anything but M lands in U
                    m_mpp  = (new_val[12:11] == 2'b11) ? 2'b11 : 2'b00;
                end
                12'h304: m_mtie     = new_val[7];
                12'h305: m_mtvec    = new_val;
                12'h340: m_mscratch = new_val;
                12'h341: m_mepc     = new_val;
                12'h342: m_mcause   = new_val;
                default: begin
                end
            endcase
        end
        exp_q.push_back(e);
    endtask

    // Samples outputs on the falling edge and releases req_valid
    task automatic step();
        csr_pkg::csr_rsp_t e;
        @(negedge clk);
        check_val("credit_return", credit_return, rsp_valid);
        if (irq_stall) begin
            check_val("rsp_valid", rsp_valid, 1'b0);
        end
        if (rsp_valid) begin
            if (exp_q.size() == 0) begin
                fail_run("a response arrived with no request outstanding");
            end
            e = exp_q.pop_front();
            check_val("rsp.kind", rsp.kind, e.kind);
            check_val("rsp.rdata", rsp.rdata, e.rdata);
            check_val("rsp.target", rsp.target, e.target);
        end
        if (credit_return) begin
            credits++;
        end
        if (credits > `CSR_QDEPTH) begin
            fail_run("more credits came back than requests were sent");
        end
        req_valid = 1'b0;
    endtask

    task automatic send(input csr_pkg::csr_req_t r, input logic take_irq);
        int n;
        n = 0;
        step();
        while (credits == 0) begin
            step();
            n++;
            if (n > 50) begin
                fail_run("no credit came back while waiting to send");
            end
        end
        req_valid = 1'b1;
        req       = r;
        credits--;
        model_exec(r, take_irq);
    endtask

    // S with zero operand reads without changing anything
    task automatic read_csr(input logic [11:0] addr);
        send(make_req(csr_pkg::CSR_S, addr, 32'h0, 32'h0), 1'b0);
    endtask

    // Waits for all responses, then one quiet cycle with every credit back
    task automatic drain();
        int n;
        n = 0;
        while (exp_q.size() != 0) begin
            step();
            n++;
            if (n > 50) begin
                fail_run("responses stopped before all requests retired");
            end
        end
        step();
        check_val("credits", credits, `CSR_QDEPTH);
    endtask

    function automatic logic [11:0] pick_addr();
        case ($unsigned($random(seed)) % 12)
            0:       return 12'h340;
            1:       return 12'h305;
            2:       return 12'h304;
            3:       return 12'h300;
            4:       return 12'h341;
            5:       return 12'h342;
            6:       return 12'hc01;
            7:       return 12'hc81;
            // mtval, mip, a custom slot and mvendorid are unowned
            8:       return 12'h343;
            9:       return 12'h344;
            10:      return 12'h7c0;
            default: return 12'hf11;
        endcase
    endfunction

    initial begin
        int                i;
        int                pick;
        int                n;
        int                saved;
        csr_pkg::csr_op_e  op;
        logic [31:0]       pc;
        seed       = 28122;
        req_valid  = 1'b0;
        req        = '0;
        time_now   = 64'h0000_0001_2345_6789;
        mtimecmp   = '1;
        irq_ready  = 1'b1;
        credits    = `CSR_QDEPTH;
        m_mode     = 2'b11;
        m_mie      = 1'b0;
        m_mpie     = 1'b0;
        m_mpp      = 2'b00;
        m_mepc     = '0;
        m_mcause   = '0;
        m_mscratch = '0;
        m_mtvec    = `CSR_MTVEC_RST;
        m_mtie     = 1'b0;

        n = 0;
        while (rst_n !== 1'b1) begin
            @(negedge clk);
            n++;
            if (n > 20) begin
                fail_run("reset was never released");
            end
        end

        // ECALL from M, MPP mapping, MRET into U, ECALL from U
        send(make_req(csr_pkg::CSR_ECALL, 12'h0, 32'h0, 32'h0000_1000), 1'b0);
        read_csr(12'h342);
        read_csr(12'h341);
        read_csr(12'h300);
        send(make_req(csr_pkg::CSR_W, 12'h300, 32'hffff_0880, 32'h0), 1'b0);
        read_csr(12'h300);
        send(make_req(csr_pkg::CSR_S, 12'h300, 32'h0000_0008, 32'h0), 1'b0);
        send(make_req(csr_pkg::CSR_MRET, 12'h0, 32'h0, 32'h0), 1'b0);
        read_csr(12'h300);
        send(make_req(csr_pkg::CSR_ECALL, 12'h0, 32'h0, 32'h0000_2004), 1'b0);
        read_csr(12'h342);
        read_csr(12'h341);
        read_csr(12'h300);
        send(make_req(csr_pkg::CSR_W, 12'h304, 32'hffff_ffff, 32'h0), 1'b0);
        read_csr(12'h304);
        read_csr(12'hc01);
        read_csr(12'hc81);
        drain();

        // Random traffic with no timer interrupt possible
        for (i = 0; i < 400; i++) begin
            if (exp_q.size() == 0 && ($random(seed) & 7) == 0) begin
                time_now     = {$random(seed), $random(seed)};
                time_now[63] = 1'b0;
            end
            pick = $unsigned($random(seed)) % 16;
            pc   = $random(seed) & 32'hffff_fffc;
            if (pick < 5) begin
                op = csr_pkg::CSR_W;
            end else if (pick < 9) begin
                op = csr_pkg::CSR_S;
            end else if (pick < 12) begin
                op = csr_pkg::CSR_C;
            end else if (pick == 12) begin
                op = csr_pkg::CSR_NOP;
            end else if (pick == 13) begin
                op = csr_pkg::CSR_ECALL;
            end else begin
                op = csr_pkg::CSR_MRET;
            end
            if (pick == 15) begin
                step();
            end else begin
                send(make_req(op, pick_addr(), $random(seed), pc), 1'b0);
            end
        end
        drain();

        // Timer interrupt entered from M with MIE set
        send(make_req(csr_pkg::CSR_ECALL, 12'h0, 32'h0, 32'h0000_3000), 1'b0);
        send(make_req(csr_pkg::CSR_W, 12'h304, 32'h0000_0080, 32'h0), 1'b0);
        send(make_req(csr_pkg::CSR_W, 12'h300, 32'h0000_0008, 32'h0), 1'b0);
        drain();
        mtimecmp  = 64'h0000_0000_0000_1000;
        time_now  = 64'h0000_0000_0000_2000;
        irq_ready = 1'b0;
        step();
        check_val("irq_stall", irq_stall, 1'b1);
        send(make_req(csr_pkg::CSR_W, 12'h340, 32'hcafe_0001, 32'h0000_4440), 1'b1);
        send(make_req(csr_pkg::CSR_S, 12'hc01, 32'h0, 32'h0000_4444), 1'b0);
        saved = credits;
        for (i = 0; i < 6; i++) begin
            step();
            check_val("irq_stall", irq_stall, 1'b1);
            check_val("rsp_valid", rsp_valid, 1'b0);
        end
        check_val("credits", credits, saved);
        irq_ready = 1'b1;
        drain();
        read_csr(12'h341);
        read_csr(12'h342);
        read_csr(12'h300);
        read_csr(12'h340);
        drain();

        // Back to no interrupt, then time reads at a new value
        mtimecmp = '1;
        time_now = 64'h0123_4567_89ab_cdef;
        read_csr(12'hc01);
        read_csr(12'hc81);
        drain();

        $display(">>> PASS");
        $finish;
    end

endmodule

/* files.f */
+incdir+src
src/csr_pkg.sv
src/csr_req_queue.sv
src/csr_regfile.sv
src/csr_trap_ctrl.sv
src/csr_rsp_stage.sv
src/csr_unit.sv
tests/csr_clk_gen.sv
tests/csr_props.sv
tests/csr_tb.sv
